// File: logic/fbPkg.sv
// **********************************************************
// package with the panel geometry, address field widths,
// the APB phase and operation enums and the command structs
// **********************************************************
`default_nettype none

package fbPkg;

    // panel geometry
    localparam int panelWidth = 64;
    // rows in one half, two halves stacked make the 32 row panel
    localparam int halfRows   = 16;
    localparam int numHalves  = 2;
    // R, G, B and a spare byte per pixel
    localparam int colorSlots = 4;

    // one lane per half and colour slot pair
    localparam int numLanes   = numHalves * colorSlots;

    // address fields
    localparam int colorBits   = $clog2(colorSlots);
    // lane address is row then column
    localparam int bodyBits    = $clog2(halfRows) + $clog2(panelWidth);
    // half, body, colour slot from msb down
    localparam int pixAddrBits = $clog2(numHalves) + bodyBits + colorBits;

    // control register, scanEnable in bit 0
    localparam logic [15:0] ctrlAddr = 16'h8000;

    // step of the current APB transfer
    typedef enum logic [1:0] {
        phIdle,
        phAccess,
        phWait
    } apbPhase;

    // decoded operation
    typedef enum logic [2:0] {
        opNone,
        opPixWrite,
        opPixRead,
        opCtrlWrite,
        opCtrlRead,
        opBad
    } fbOp;

    // decoder command to the memory and the response path
    typedef struct packed {
        fbOp                          op;
        logic [$clog2(numLanes)-1:0]  lane;
        logic [bodyBits-1:0]          body;
        logic [7:0]                   data;
    } memCmd;

    // one column of scan output, rgb packed with red on top
    typedef struct packed {
        logic [$clog2(halfRows)-1:0]   row;
        logic [$clog2(panelWidth)-1:0] column;
        logic [23:0]                   topRgb;
        logic [23:0]                   botRgb;
    } scanBeat;

endpackage

`default_nettype wire

// File: logic/fbDecode.sv
// **********************************************************
// APB phase tracking and address decode into one registered
// memory or register command per transfer
// **********************************************************
`default_nettype none

module fbDecode import fbPkg::*; (
    input  logic        ClockA,
    input  logic        arstN,
    input  logic        PSEL,
    input  logic        PENABLE,
    input  logic        PWRITE,
    input  logic [15:0] PADDR,
    input  logic [31:0] PWDATA,
    input  logic        PREADY,
    output memCmd       cmd,
    output logic        cmdValid
);

    apbPhase                phase;
    fbOp                    opNext;
    logic [pixAddrBits-1:0] pixAddr;
    logic                   pixRegion;
    logic                   accessStart;

    // pixel address sits in the low bits of PADDR
    assign pixAddr = PADDR[pixAddrBits-1:0];
    // everything above the pixel field must be zero for a pixel access
    assign pixRegion = (PADDR[15:pixAddrBits] == '0);

    // first access cycle only, later wait cycles are ignored
    assign accessStart = (phase == phAccess) && PSEL && PENABLE;

    // classify the address
    always_comb begin
        if (PADDR == ctrlAddr) begin
            opNext = PWRITE ? opCtrlWrite : opCtrlRead;
        end else if (pixRegion) begin
            opNext = PWRITE ? opPixWrite : opPixRead;
        end else begin
            opNext = opBad;
        end
    end

    // phase tracking, one decode per transfer
    always_ff @(posedge ClockA or negedge arstN) begin
        if (!arstN) begin
            phase <= phIdle;
        end else begin
            case (phase)
                phIdle: begin
                    // setup cycle seen
                    if (PSEL && !PENABLE) begin
                        phase <= phAccess;
                    end
                end
                phAccess: begin
                    if (PSEL && PENABLE) begin
                        phase <= phWait;
                    end
                end
                phWait: begin
                    // transfer completes on this edge
                    if (PREADY) begin
                        phase <= phIdle;
                    end
                end
                default: begin
                    phase <= phIdle;
                end
            endcase
        end
    end

    // registered command and its strobe
    always_ff @(posedge ClockA or negedge arstN) begin
        if (!arstN) begin
            cmd      <= '0;
            cmdValid <= 1'b0;
        end else begin
            cmdValid <= accessStart;
            if (accessStart) begin
                cmd.op   <= opNext;
                // lane is half bit joined with the colour slot
                cmd.lane <= {pixAddr[pixAddrBits-1], pixAddr[colorBits-1:0]};
                cmd.body <= pixAddr[colorBits +: bodyBits];
                // only the low byte is ever stored
                cmd.data <= PWDATA[7:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/fbLane.sv
// **********************************************************
// one byte-wide lane, one write port, two registered reads
// **********************************************************
`default_nettype none

module fbLane import fbPkg::*; (
    input  logic                ClockA,
    input  logic                wrEn,
    input  logic [bodyBits-1:0] wrAddr,
    input  logic [7:0]          wrData,
    input  logic [bodyBits-1:0] rdAddrA,
    output logic [7:0]          rdDataA,
    input  logic                rdEnB,
    input  logic [bodyBits-1:0] rdAddrB,
    output logic [7:0]          rdDataB
);

    // 1024 bytes, one per row and column of one half and slot
    logic [7:0] mem [1 << bodyBits];

    always_ff @(posedge ClockA) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
        // APB side reads every cycle
        rdDataA <= mem[rdAddrA];
        // scan side holds its output while disabled
        if (rdEnB) begin
            rdDataB <= mem[rdAddrB];
        end
    end

endmodule

`default_nettype wire

// File: logic/fbBanks.sv
// **********************************************************
// eight lanes with registered write steering, the APB read
// mux and the wide scan read port
// **********************************************************
`default_nettype none

module fbBanks import fbPkg::*; (
    input  logic                  ClockA,
    input  logic                  arstN,
    input  memCmd                 cmd,
    input  logic                  cmdValid,
    output logic [7:0]            laneData,
    input  logic                  scanEn,
    input  logic [bodyBits-1:0]   scanBody,
    output logic [numLanes*8-1:0] scanWord
);

    // port A outputs of all lanes
    logic [7:0]                  laneRd [numLanes];
    // lane picked by the last command to line up with the read latency
    logic [$clog2(numLanes)-1:0] rdLaneQ;

    always_ff @(posedge ClockA) begin
        rdLaneQ <= cmd.lane;
    end

    assign laneData = laneRd[rdLaneQ];

    for (genvar i = 0; i < numLanes; i++) begin : gLane
        logic                wrEnQ;
        logic [bodyBits-1:0] wrAddrQ;
        logic [7:0]          wrDataQ;
        logic                wrHit;

        // this lane is the target of a pixel write
        assign wrHit = cmdValid && (cmd.op == opPixWrite) &&
                       (cmd.lane == i[$clog2(numLanes)-1:0]);

        // registered write enable of this lane
        always_ff @(posedge ClockA or negedge arstN) begin
            if (!arstN) begin
                wrEnQ <= 1'b0;
            end else begin
                wrEnQ <= wrHit;
            end
        end

        // registered write address and data
        always_ff @(posedge ClockA) begin
            wrAddrQ <= cmd.body;
            wrDataQ <= cmd.data;
        end

        fbLane lane0 (
            .ClockA  (ClockA),
            .wrEn    (wrEnQ),
            .wrAddr  (wrAddrQ),
            .wrData  (wrDataQ),
            .rdAddrA (cmd.body),
            .rdDataA (laneRd[i]),
            .rdEnB   (scanEn),
            .rdAddrB (scanBody),
            // lane 0 in the lowest byte
            .rdDataB (scanWord[i*8 +: 8])
        );
    end

endmodule

`default_nettype wire

// File: logic/fbResponse.sv
// **********************************************************
// control register, PRDATA, PREADY and PSLVERR
// **********************************************************
`default_nettype none

module fbResponse import fbPkg::*; (
    input  logic        ClockA,
    input  logic        arstN,
    input  memCmd       cmd,
    input  logic        cmdValid,
    input  logic [7:0]  laneData,
    output logic [31:0] PRDATA,
    output logic        PREADY,
    output logic        PSLVERR,
    output logic        scanEnable
);

    // pixel read waiting one cycle for its lane data
    logic pendRead;

    always_ff @(posedge ClockA or negedge arstN) begin
        if (!arstN) begin
            pendRead   <= 1'b0;
            scanEnable <= 1'b0;
        end else begin
            pendRead <= cmdValid && (cmd.op == opPixRead);
            if (cmdValid && (cmd.op == opCtrlWrite)) begin
                scanEnable <= cmd.data[0];
            end
        end
    end

    // everything but a pixel read finishes with the strobe
    assign PREADY = (cmdValid && (cmd.op != opPixRead)) || pendRead;

    // only bad addresses fail
    assign PSLVERR = cmdValid && (cmd.op == opBad);

    // read data, zero outside a completing read
    always_comb begin
        if (pendRead) begin
            PRDATA = {24'd0, laneData};
        end else if (cmdValid && (cmd.op == opCtrlRead)) begin
            PRDATA = {31'd0, scanEnable};
        end else begin
            PRDATA = '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/fbScan.sv
// **********************************************************
// row and column sweep of the store into scan beats, with
// valid and ready back-pressure
// **********************************************************
`default_nettype none

module fbScan import fbPkg::*; (
    input  logic                  ClockA,
    input  logic                  arstN,
    input  logic                  scanEnable,
    output logic                  scanEn,
    output logic [bodyBits-1:0]   scanBody,
    input  logic [numLanes*8-1:0] scanWord,
    output logic                  beatValid,
    output scanBeat               beat,
    input  logic                  beatReady
);

    // delayed enable, gives the two cycle start
    logic                run;
    // a fetched read is waiting in scanWord
    logic                inFlight;
    // next location to read, row in the upper bits so it wraps row then column
    logic [bodyBits-1:0] nextBody;
    // location of the beat held in scanWord
    logic [bodyBits-1:0] beatBody;
    logic                issue;

    // read only when the held beat leaves or there is none
    assign issue = run && scanEnable && (!inFlight || beatReady);

    assign scanEn    = issue;
    assign scanBody  = nextBody;
    assign beatValid = inFlight;

    always_ff @(posedge ClockA or negedge arstN) begin
        if (!arstN) begin
            run      <= 1'b0;
            inFlight <= 1'b0;
            nextBody <= '0;
        end else begin
            run <= scanEnable;
            // disabled scan restarts at row 0, column 0
            if (!scanEnable) begin
                nextBody <= '0;
            end else if (issue) begin
                nextBody <= nextBody + 1'b1;
            end
            // a new read replaces the taken beat, otherwise the taken beat clears
            if (issue) begin
                inFlight <= 1'b1;
            end else if (beatReady) begin
                inFlight <= 1'b0;
            end
        end
    end

    // position follows the read it belongs to
    always_ff @(posedge ClockA) begin
        if (issue) begin
            beatBody <= nextBody;
        end
    end

    // beat straight from the held lane bytes, stable while stalled
    always_comb begin
        {beat.row, beat.column} = beatBody;
        // top half, lanes 0 to 2 as R, G, B
        beat.topRgb = {scanWord[0*8 +: 8], scanWord[1*8 +: 8], scanWord[2*8 +: 8]};
        // bottom half, lanes 4 to 6
        beat.botRgb = {scanWord[4*8 +: 8], scanWord[5*8 +: 8], scanWord[6*8 +: 8]};
    end

endmodule

`default_nettype wire

// File: logic/fbTop.sv
// **********************************************************
// top level, APB slave, banked store and scan stream
// **********************************************************
`default_nettype none

module fbTop import fbPkg::*; (
    input  logic        ClockA,
    input  logic        arstN,
    input  logic        PSEL,
    input  logic        PENABLE,
    input  logic        PWRITE,
    input  logic [15:0] PADDR,
    input  logic [31:0] PWDATA,
    output logic [31:0] PRDATA,
    output logic        PREADY,
    output logic        PSLVERR,
    output logic        beatValid,
    output scanBeat     beat,
    input  logic        beatReady
);

    memCmd                  cmd;
    logic                   cmdValid;
    logic [7:0]             laneData;
    logic                   scanEnable;
    // second memory port
    logic                   scanEn;
    logic [bodyBits-1:0]    scanBody;
    logic [numLanes*8-1:0]  scanWord;

    fbDecode decode0 (
        .ClockA   (ClockA),
        .arstN    (arstN),
        .PSEL     (PSEL),
        .PENABLE  (PENABLE),
        .PWRITE   (PWRITE),
        .PADDR    (PADDR),
        .PWDATA   (PWDATA),
        .PREADY   (PREADY),
        .cmd      (cmd),
        .cmdValid (cmdValid)
    );

    fbBanks banks0 (
        .ClockA   (ClockA),
        .arstN    (arstN),
        .cmd      (cmd),
        .cmdValid (cmdValid),
        .laneData (laneData),
        .scanEn   (scanEn),
        .scanBody (scanBody),
        .scanWord (scanWord)
    );

    fbResponse response0 (
        .ClockA     (ClockA),
        .arstN      (arstN),
        .cmd        (cmd),
        .cmdValid   (cmdValid),
        .laneData   (laneData),
        .PRDATA     (PRDATA),
        .PREADY     (PREADY),
        .PSLVERR    (PSLVERR),
        .scanEnable (scanEnable)
    );

    fbScan scan0 (
        .ClockA     (ClockA),
        .arstN      (arstN),
        .scanEnable (scanEnable),
        .scanEn     (scanEn),
        .scanBody   (scanBody),
        .scanWord   (scanWord),
        .beatValid  (beatValid),
        .beat       (beat),
        .beatReady  (beatReady)
    );

endmodule

`default_nettype wire

// File: verification/fbTb.sv
// **********************************************************
// testbench for fbTop, APB cases from a file, a shadow of
// the pixel store, scan beat checks with random stalls
// **********************************************************
`default_nettype none

module fbTb import fbPkg::*; ();

    localparam int frameBeats  = halfRows * panelWidth;
    // rgb slots of both halves for every column
    localparam int fillWrites  = frameBeats * numHalves * 3;
    localparam int maxCases    = 32;
    localparam int resetCycles = 4;
    localparam int rowBits     = $clog2(halfRows);
    localparam int colBits     = $clog2(panelWidth);

    logic        ClockA;
    logic        arstN;
    logic        PSEL;
    logic        PENABLE;
    logic        PWRITE;
    logic [15:0] PADDR;
    logic [31:0] PWDATA;
    logic [31:0] PRDATA;
    logic        PREADY;
    logic        PSLVERR;
    logic        beatValid;
    scanBeat     beat;
    logic        beatReady;

    // case table loaded from the data file
    logic [8*24-1:0] caseName  [maxCases];
    logic [7:0]      caseDir   [maxCases];
    logic [15:0]     caseAddr  [maxCases];
    logic [31:0]     caseWdata [maxCases];
    logic [31:0]     caseRdata [maxCases];
    logic            caseErr   [maxCases];
    int              numCases;

    // every byte the store should hold by pixel address
    logic [7:0] shadow [1 << pixAddrBits];

    int      cycleCount;
    int      cycleLimit;
    int      beatCount;
    // access cycles with PREADY low in the last transfer
    int      waitCycles;
    logic    scanCheck;
    // a beat was seen waiting on the last falling edge
    logic    holdPending;
    scanBeat heldBeat;
    logic    stallMode;

    fbTop dut0 (
        .ClockA    (ClockA),
        .arstN     (arstN),
        .PSEL      (PSEL),
        .PENABLE   (PENABLE),
        .PWRITE    (PWRITE),
        .PADDR     (PADDR),
        .PWDATA    (PWDATA),
        .PRDATA    (PRDATA),
        .PREADY    (PREADY),
        .PSLVERR   (PSLVERR),
        .beatValid (beatValid),
        .beat      (beat),
        .beatReady (beatReady)
    );

    always #5 ClockA = ~ClockA;

    task automatic abortRun();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic expectEqual(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual == expected) else begin
            $display("MISMATCH %s expected 0x%0h actual 0x%0h", what, expected, actual);
            abortRun();
        end
    endtask

    // one APB transfer with setup then access until PREADY
    task automatic apbTransfer(input logic write, input logic [15:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic slverr);
        @(posedge ClockA);
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        PWRITE  <= write;
        PADDR   <= addr;
        PWDATA  <= wdata;
        @(posedge ClockA);
        PENABLE <= 1'b1;
        // response sampled mid cycle away from the edge
        @(negedge ClockA);
        waitCycles = 0;
        while (!PREADY) begin
            waitCycles = waitCycles + 1;
            @(negedge ClockA);
        end
        rdata  = PRDATA;
        slverr = PSLVERR;
        @(posedge ClockA);
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
    endtask

    task automatic writePixel(input logic [pixAddrBits-1:0] pix, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        slverr;
        apbTransfer(1'b1, 16'(pix), wdata, rdata, slverr);
        expectEqual("fill PSLVERR", 64'(1'b0), 64'(slverr));
        // only the low byte lands in the store
        shadow[pix] = wdata[7:0];
    endtask

    // beat number index of the sweep with row above column and red in the top byte
    function automatic scanBeat expectedBeat(input int index);
        scanBeat             b;
        logic [bodyBits-1:0] body;
        body     = bodyBits'(index % frameBeats);
        b.row    = body[colBits +: rowBits];
        b.column = body[0 +: colBits];
        b.topRgb = {shadow[{1'b0, body, 2'd0}], shadow[{1'b0, body, 2'd1}],
                    shadow[{1'b0, body, 2'd2}]};
        b.botRgb = {shadow[{1'b1, body, 2'd0}], shadow[{1'b1, body, 2'd1}],
                    shadow[{1'b1, body, 2'd2}]};
        return b;
    endfunction

    always @(posedge ClockA) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, a transfer or the scan stalled", cycleCount);
            abortRun();
        end
    end

    // ready held high for the first frame and gapped at random in the second
    assign stallMode = (beatCount >= frameBeats);

    always @(posedge ClockA) begin
        if (stallMode) begin
            beatReady <= (($urandom % 5) >= 2);
        end else begin
            beatReady <= 1'b1;
        end
    end

    // beat monitor on the falling edge where a transfer is valid and ready together
    always @(negedge ClockA) begin
        if (scanCheck) begin
            if (holdPending) begin
                assert (beatValid) else begin
                    $display("beatValid dropped while beat %0d was stalled", beatCount);
                    abortRun();
                end
                expectEqual($sformatf("beat%0d hold", beatCount), 64'(heldBeat), 64'(beat));
            end
            if (beatValid && beatReady) begin
                expectEqual($sformatf("beat%0d", beatCount), 64'(expectedBeat(beatCount)),
                            64'(beat));
                beatCount   = beatCount + 1;
                holdPending = 1'b0;
            end else if (beatValid) begin
                holdPending = 1'b1;
                heldBeat    = beat;
            end
        end
    end

    initial begin
        int              fd;
        int              fields;
        int              expWaits;
        logic [8*160-1:0] lineBuf;
        logic [8*24-1:0] nameTok;
        logic [7:0]      dirTok;
        logic [31:0]     addrTok;
        logic [31:0]     wdataTok;
        logic [31:0]     rdataTok;
        logic [31:0]     errTok;
        logic [31:0]     rdata;
        logic            slverr;
        void'($urandom(13));
        ClockA      = 1'b0;
        arstN       = 1'b0;
        PSEL        = 1'b0;
        PENABLE     = 1'b0;
        PWRITE      = 1'b0;
        PADDR       = '0;
        PWDATA      = '0;
        beatReady   = 1'b1;
        cycleCount  = 0;
        beatCount   = 0;
        waitCycles  = 0;
        scanCheck   = 1'b0;
        holdPending = 1'b0;
        heldBeat    = '0;
        numCases    = 0;
        fd = $fopen("verification/fbCases.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/fbCases.txt");
            abortRun();
        end
        while ($fgets(lineBuf, fd) != 0) begin
            fields = $sscanf(lineBuf, "%s %s %h %h %h %h", nameTok, dirTok, addrTok,
                             wdataTok, rdataTok, errTok);
            // comment and blank lines never give six fields
            if (fields == 6 && numCases < maxCases) begin
                caseName[numCases]  = nameTok;
                caseDir[numCases]   = dirTok;
                caseAddr[numCases]  = addrTok[15:0];
                caseWdata[numCases] = wdataTok;
                caseRdata[numCases] = rdataTok;
                caseErr[numCases]   = errTok[0];
                numCases = numCases + 1;
            end
        end
        $fclose(fd);
        // 10 cycles per APB transfer and 4 per beat over two frames
        cycleLimit = resetCycles + (numCases + fillWrites + 1) * 10 + 2 * frameBeats * 4;

        repeat (resetCycles) @(posedge ClockA);
        arstN <= 1'b1;

        // directed APB cases
        for (int i = 0; i < numCases; i++) begin
            apbTransfer(caseDir[i] == "W", caseAddr[i], caseWdata[i], rdata, slverr);
            expectEqual($sformatf("%0s PSLVERR", caseName[i]), 64'(caseErr[i]), 64'(slverr));
            if (caseDir[i] != "W" || caseErr[i]) begin
                expectEqual($sformatf("%0s PRDATA", caseName[i]), 64'(caseRdata[i]),
                            64'(rdata));
            end
            // pixel reads wait one more cycle for the lane data
            expWaits = (caseDir[i] != "W" && caseAddr[i][15:pixAddrBits] == '0) ? 2 : 1;
            expectEqual($sformatf("%0s wait cycles", caseName[i]), 64'(expWaits),
                        64'(waitCycles));
            if (caseDir[i] == "W" && !caseErr[i] && caseAddr[i][15:pixAddrBits] == '0) begin
                shadow[caseAddr[i][pixAddrBits-1:0]] = caseWdata[i][7:0];
            end
        end

        // random frame in the scanned slots of both halves
        for (int b = 0; b < frameBeats; b++) begin
            for (int half = 0; half < numHalves; half++) begin
                for (int slot = 0; slot < 3; slot++) begin
                    writePixel({half[0], b[bodyBits-1:0], slot[colorBits-1:0]}, $urandom);
                end
            end
        end

        // scan two frames so the second one wraps back to row 0
        scanCheck = 1'b1;
        apbTransfer(1'b1, ctrlAddr, 32'h1, rdata, slverr);
        expectEqual("scan enable PSLVERR", 64'(1'b0), 64'(slverr));
        wait (beatCount >= 2 * frameBeats);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/fbCases.txt
# columns: name, W or R, PADDR, PWDATA, expected PRDATA, expected PSLVERR
# pixel PADDR holds half 12, row 11:8, column 7:2, slot 1:0, PRDATA checked on reads and errors
wrTopRed     W 0000 000000a5 00000000 0
rdTopRed     R 0000 00000000 000000a5 0
wrTopGreen   W 0001 ffffff3c 00000000 0
rdTopGreen   R 0001 00000000 0000003c 0
wrTopBlue    W 0126 12345677 00000000 0
rdTopBlue    R 0126 00000000 00000077 0
wrTopSpare   W 0003 000000c9 00000000 0
rdTopSpare   R 0003 00000000 000000c9 0
wrBotRed     W 1000 0000005e 00000000 0
rdBotRed     R 1000 00000000 0000005e 0
rdTopKeep    R 0000 00000000 000000a5 0
wrBotSpare   W 1fff 000000ff 00000000 0
rdBotSpare   R 1fff 00000000 000000ff 0
wrCtrlOn     W 8000 ffffffff 00000000 0
rdCtrlOn     R 8000 00000000 00000001 0
wrCtrlOff    W 8000 000000fe 00000000 0
rdCtrlOff    R 8000 00000000 00000000 0
wrBadAlias   W 2000 00000011 00000000 1
rdAliasKeep  R 0000 00000000 000000a5 0
rdBadHigh    R 8004 00000000 00000000 1
wrBadMid     W 4001 00000022 00000000 1
rdAliasGreen R 0001 00000000 0000003c 0

// File: sim.f
logic/fbPkg.sv
logic/fbDecode.sv
logic/fbLane.sv
logic/fbBanks.sv
logic/fbResponse.sv
logic/fbScan.sv
logic/fbTop.sv
verification/fbTb.sv

// File: run.sh
#!/usr/bin/env bash
# build the fbTb simulation with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module fbTb -f sim.f -o fbSim

# a failing run exits non-zero, the output still decides the result
output=$(./obj_dir/fbSim) || true
echo "$output"

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
